/* hw/trace_decode.sv */
// Trace record decode stage
`timescale 1ns/1ps

module trace_decode (
   input  logic                clk,
   input  logic                reset_i,
   input  trace_pkg::trace_t   trace_i,
   input  logic                halt_i,
   output trace_pkg::decoded_t dec_o
);

   trace_pkg::nop_op_e  op_d;
   logic                is_nop;
   trace_pkg::decoded_t dec_q;

   // l.nop carries its code in the low immediate half
   assign is_nop = (trace_i.insn[31:24] == trace_pkg::NOP_OPCODE);

   always_comb begin
      op_d = trace_pkg::OP_NONE;
      if (is_nop) begin
         // Other immediates are plain no-ops
         case (trace_i.insn[15:0])
            trace_pkg::NOP_EXIT:   op_d = trace_pkg::OP_EXIT;
            trace_pkg::NOP_REPORT: op_d = trace_pkg::OP_REPORT;
            trace_pkg::NOP_PUTC:   op_d = trace_pkg::OP_PUTC;
            default:               op_d = trace_pkg::OP_NONE;
         endcase
      end
   end

   // Valid bit, dropped once the result stage has seen an exit
   always_ff @(posedge clk) begin
      if (reset_i) begin
         dec_q.valid <= 1'b0;
      end else begin
         dec_q.valid <= trace_i.valid & ~halt_i;
      end
   end

   // Payload fields
   always_ff @(posedge clk) begin
      dec_q.op     <= op_d;
      dec_q.pc     <= trace_i.pc;
      dec_q.wben   <= trace_i.wben;
      dec_q.wbreg  <= trace_i.wbreg;
      dec_q.wbdata <= trace_i.wbdata;
   end

   assign dec_o = dec_q;

endmodule

/* hw/trace_execute.sv */
// Shadow r3 and event formation
`timescale 1ns/1ps

module trace_execute (
   input  logic                clk,
   input  logic                reset_i,
   input  trace_pkg::decoded_t dec_i,
   output trace_pkg::event_t   evt_o,
   output logic                evt_valid_o
);

   logic [31:0]       r3_q;
   logic              r3_we;
   logic              is_event;
   logic [31:0]       value_d;
   trace_pkg::event_t evt_q;
   logic              evt_valid_q;

   // Writeback to r3 from a valid record, r3 holds the report and putc argument
   assign r3_we = dec_i.valid & dec_i.wben & (dec_i.wbreg == 5'd3);

   // Shadow r3
   // written in this stage, so the record just before a no-op is already in r3_q
   always_ff @(posedge clk) begin
      if (reset_i) begin
         r3_q <= 32'h0;
      end else if (r3_we) begin
         r3_q <= dec_i.wbdata;
      end
   end

   assign is_event = dec_i.valid & (dec_i.op != trace_pkg::OP_NONE);

   // Putc only carries the character byte
   always_comb begin
      if (dec_i.op == trace_pkg::OP_PUTC) begin
         value_d = {24'h0, r3_q[7:0]};
      end else begin
         value_d = r3_q;
      end
   end

   // Event valid
   always_ff @(posedge clk) begin
      if (reset_i) begin
         evt_valid_q <= 1'b0;
      end else begin
         evt_valid_q <= is_event;
      end
   end

   // Event payload, only loaded for real events
   always_ff @(posedge clk) begin
      if (is_event) begin
         evt_q.kind  <= dec_i.op;
         evt_q.value <= value_d;
         evt_q.pc    <= dec_i.pc;
      end
   end

   assign evt_o       = evt_q;
   assign evt_valid_o = evt_valid_q;

endmodule

/* hw/trace_monitor.sv */
// Retirement trace monitor top
`timescale 1ns/1ps

module trace_monitor (
   input  logic              clk,
   input  logic              reset_i,
   input  trace_pkg::trace_t trace_i,
   input  logic              credit_i,
   output trace_pkg::event_t event_o,
   output logic              event_valid_o,
   output logic              overflow_o,
   output logic              terminated_o
);

   trace_pkg::decoded_t dec;
   trace_pkg::event_t   evt;
   logic                evt_valid;
   logic                terminated;

   // Classify control no-ops
   trace_decode u_decode (
      .clk     (clk),
      .reset_i (reset_i),
      .trace_i (trace_i),
      .halt_i  (terminated),
      .dec_o   (dec)
   );

   // Track r3, build events
   trace_execute u_execute (
      .clk         (clk),
      .reset_i     (reset_i),
      .dec_i       (dec),
      .evt_o       (evt),
      .evt_valid_o (evt_valid)
   );

   // Queue and credit handshake
   trace_result u_result (
      .clk           (clk),
      .reset_i       (reset_i),
      .evt_i         (evt),
      .evt_valid_i   (evt_valid),
      .credit_i      (credit_i),
      .event_o       (event_o),
      .event_valid_o (event_valid_o),
      .overflow_o    (overflow_o),
      .terminated_o  (terminated)
   );

   // Exit also stops decode
   assign terminated_o = terminated;

endmodule

/* hw/trace_pkg.sv */
// Retirement trace monitor types
package trace_pkg;

   // Upper instruction byte of l.nop
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // Simulation control immediates
   localparam logic [15:0] NOP_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_REPORT = 16'h0002;
   localparam logic [15:0] NOP_PUTC   = 16'h0004;

   // Credit counter and event queue sizing
   localparam int unsigned CREDIT_W    = 3;
   localparam int unsigned QUEUE_PTR_W = 2;

   typedef logic [CREDIT_W-1:0]  credit_t;
   typedef logic [QUEUE_PTR_W-1:0] qptr_t;
   // One extra bit so a full queue is distinguishable from empty
   typedef logic [QUEUE_PTR_W:0]   qcnt_t;

   // Consumer buffer depth, also the credit count after reset
   localparam credit_t EVENT_CREDITS = credit_t'(4);
   localparam qcnt_t   QUEUE_DEPTH   = qcnt_t'(4);

   // One retired instruction from the core
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_t;

   // Control no-op classes
   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_EXIT   = 2'd1,
      OP_REPORT = 2'd2,
      OP_PUTC   = 2'd3
   } nop_op_e;

   // Decode to execute record, insn replaced by its class
   typedef struct packed {
      logic        valid;
      nop_op_e     op;
      logic [31:0] pc;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } decoded_t;

   // Event to the consumer
   typedef struct packed {
      nop_op_e     kind;
      logic [31:0] value;
      logic [31:0] pc;
   } event_t;

endpackage

/* hw/trace_result.sv */
// Event queue with credit flow control
`timescale 1ns/1ps

module trace_result (
   input  logic              clk,
   input  logic              reset_i,
   input  trace_pkg::event_t evt_i,
   input  logic              evt_valid_i,
   input  logic              credit_i,
   output trace_pkg::event_t event_o,
   output logic              event_valid_o,
   output logic              overflow_o,
   output logic              terminated_o
);

   // Queue storage
   trace_pkg::event_t mem_q [trace_pkg::QUEUE_DEPTH];

   trace_pkg::qptr_t   wr_ptr_q;
   trace_pkg::qptr_t   rd_ptr_q;
   trace_pkg::qcnt_t   count_q;
   trace_pkg::credit_t credit_q;
   trace_pkg::credit_t credit_sum;
   logic               overflow_q;
   logic               terminated_q;
   logic               empty;
   logic               full;
   logic               arrive;
   logic               send;
   logic               push;
   logic               drop;

   assign empty = (count_q == '0);
   assign full  = (count_q == trace_pkg::QUEUE_DEPTH);

   // Nothing accepted after exit
   assign arrive = evt_valid_i & ~terminated_q;

   // Head leaves whenever the consumer has room
   assign send = ~empty & (credit_q != '0);

   // A slot freed by this cycle's send can take the arrival
   assign push = arrive & (~full | send);
   assign drop = arrive & full & ~send;

   // Write into an empty queue lands at the head, so it goes out next cycle
   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= evt_i;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (send) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + trace_pkg::qcnt_t'(push) - trace_pkg::qcnt_t'(send);
      end
   end

   // Take one for a send, give one back per pulse
   assign credit_sum = credit_q - trace_pkg::credit_t'(send)
                       + trace_pkg::credit_t'(credit_i);

   // Credit count, saturates at the consumer depth
   always_ff @(posedge clk) begin
      if (reset_i) begin
         credit_q <= trace_pkg::EVENT_CREDITS;
      end else if (credit_sum > trace_pkg::EVENT_CREDITS) begin
         credit_q <= trace_pkg::EVENT_CREDITS;
      end else begin
         credit_q <= credit_sum;
      end
   end

   // Sticky status
   always_ff @(posedge clk) begin
      if (reset_i) begin
         overflow_q   <= 1'b0;
         terminated_q <= 1'b0;
      end else begin
         if (drop) begin
            overflow_q <= 1'b1;
         end
         if (push && evt_i.kind == trace_pkg::OP_EXIT) begin
            terminated_q <= 1'b1;
         end
      end
   end

   assign event_o       = mem_q[rd_ptr_q];
   assign event_valid_o = send;
   assign overflow_o    = overflow_q;
   assign terminated_o  = terminated_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the trace monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_trace_monitor -o tb_trace_monitor
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Keep running past assertion errors so the testbench can count them
out=$(./obj_dir/tb_trace_monitor +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1

/* test/tb_trace_monitor.sv */
// Trace monitor testbench
`timescale 1ns/1ps

module tb_trace_monitor;

   localparam int MAX_OPS = 128;
   localparam int MAX_EXP = 32;

   logic              clk;
   logic              reset_i;
   trace_pkg::trace_t trace_i;
   logic              credit_i;
   trace_pkg::event_t event_o;
   logic              event_valid_o;
   logic              overflow_o;
   logic              terminated_o;

   // Test program, one slot per T or H line
   trace_pkg::trace_t op_rec [MAX_OPS];
   logic              op_is_hold [MAX_OPS];
   logic              op_hold_val [MAX_OPS];
   int                op_exp_before [MAX_OPS];
   trace_pkg::event_t exp_evt [MAX_EXP];
   int                n_ops = 0;
   int                n_recs = 0;
   int                n_exp = 0;
   logic              final_ovf = 1'b0;
   logic              final_term = 1'b0;

   // Scoreboard and consumer state
   int                errors = 0;
   int                rx_count = 0;
   int                ret_count = 0;
   int                delay = 0;
   int unsigned       cycle = 0;
   int unsigned       cycle_limit = 0;
   logic              hold = 1'b0;

   trace_monitor dut_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .trace_i       (trace_i),
      .credit_i      (credit_i),
      .event_o       (event_o),
      .event_valid_o (event_valid_o),
      .overflow_o    (overflow_o),
      .terminated_o  (terminated_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_event(input string name, input trace_pkg::event_t got,
                              input trace_pkg::event_t exp);
      if (got !== exp) begin
         // Event fields shown as kind, value, pc
         $display("MISMATCH t=%0t %s got %0d %h %h expected %0d %h %h",
                  $time, name, got.kind, got.value, got.pc, exp.kind, exp.value, exp.pc);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // Parse the test file into program and expected lists
   task automatic load_tests();
      int           fd;
      int           code;
      logic [7:0]   tag;
      logic [31:0]  c0, c1, c2, c3, c4, c5;
      logic [1023:0] rest;
      fd = $fopen("test/trace_tests.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open test/trace_tests.txt");
         errors++;
         return;
      end
      while ($fscanf(fd, "%s", tag) == 1) begin
         if (tag == "#") begin
            code = $fgets(rest, fd);
         end else if (tag == "T") begin
            code = $fscanf(fd, "%h %h %h %h %h %h", c0, c1, c2, c3, c4, c5);
            op_rec[n_ops] = '{valid: c0[0], pc: c1, insn: c2, wben: c3[0],
                              wbreg: c4[4:0], wbdata: c5};
            op_is_hold[n_ops] = 1'b0;
            n_ops++;
            n_recs++;
         end else if (tag == "H") begin
            code = $fscanf(fd, "%h", c0);
            op_is_hold[n_ops] = 1'b1;
            op_hold_val[n_ops] = c0[0];
            op_exp_before[n_ops] = n_exp;
            n_ops++;
         end else if (tag == "E") begin
            code = $fscanf(fd, "%h %h %h", c0, c1, c2);
            exp_evt[n_exp] = '{kind: trace_pkg::nop_op_e'(c0[1:0]), value: c1, pc: c2};
            n_exp++;
         end else if (tag == "F") begin
            code = $fscanf(fd, "%h %h", c0, c1);
            final_ovf = c0[0];
            final_term = c1[0];
         end else begin
            $display("ERROR: unknown line tag %c in test file", tag);
            errors++;
         end
      end
      $fclose(fd);
   endtask

   // Block until n events are in and every credit went back
   task automatic wait_drain(input int n);
      while (rx_count < n || ret_count != rx_count) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Receive side, sampled mid cycle
   always @(negedge clk) begin
      if (!reset_i && event_valid_o) begin
         if (rx_count >= n_exp) begin
            $display("ERROR: t=%0t unexpected extra event kind %0d pc %h",
                     $time, event_o.kind, event_o.pc);
            errors++;
         end else begin
            check_event("event_o", event_o, exp_evt[rx_count]);
         end
         rx_count++;
         if (rx_count - ret_count > int'(trace_pkg::EVENT_CREDITS)) begin
            $display("ERROR: t=%0t more events outstanding than consumer slots", $time);
            errors++;
         end
      end
   end

   // Consumer frees one slot per received event after 0 to 3 cycles
   initial begin
      credit_i = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         credit_i = 1'b0;
         if (!reset_i && !hold && ret_count < rx_count) begin
            if (delay == 0) begin
               credit_i = 1'b1;
               ret_count++;
               delay = int'($urandom % 4);
            end else begin
               delay--;
            end
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle_limit != 0 && cycle >= cycle_limit) begin
         $display("ERROR: timeout after %0d cycles, %0d of %0d events received",
                  cycle, rx_count, n_exp);
         $display("Errors: %0d", errors + 1);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      int i;
      void'($urandom(32'hfad35188));
      reset_i = 1'b1;
      trace_i = '0;
      load_tests();
      cycle_limit = 50 + 4 * (n_recs + n_exp);
      repeat (2) @(posedge clk);
      #1;
      reset_i = 1'b0;
      for (i = 0; i < n_ops; i++) begin
         if (op_is_hold[i]) begin
            // Release first, then let the consumer catch up
            if (!op_hold_val[i]) begin
               hold = 1'b0;
            end
            wait_drain(op_exp_before[i]);
            hold = op_hold_val[i];
         end else begin
            trace_i = op_rec[i];
            @(posedge clk);
            #1;
            trace_i = '0;
         end
      end
      wait_drain(n_exp);
      // Quiet window for stray events
      repeat (8) @(posedge clk);
      check_flag("overflow_o", overflow_o, final_ovf);
      check_flag("terminated_o", terminated_o, final_term);
      errors += int'(dut_i.u_result.u_asserts.fail_cnt);
      $display("Errors: %0d, events received %0d of %0d", errors, rx_count, n_exp);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* test/trace_monitor_asserts.sv */
// Result stage credit checks
`timescale 1ns/1ps

module trace_monitor_asserts (
   input logic               clk,
   input logic               reset_i,
   input trace_pkg::credit_t credit_cnt_i,
   input logic               credit_i,
   input logic               event_valid_i
);

   // Number of failed checks
   int unsigned fail_cnt = 0;
   // Events the consumer holds and has not freed yet
   int          outstanding;

   // Consumer side view, built from sends and returned credits only
   always_ff @(posedge clk) begin
      if (reset_i) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(event_valid_i) - int'(credit_i);
      end
   end

   // Consumer must have a free slot for every send
   send_needs_credit: assert property (@(posedge clk) disable iff (reset_i)
      event_valid_i |-> (outstanding < int'(trace_pkg::EVENT_CREDITS)))
      else begin
         fail_cnt++;
         $error("event sent while every consumer slot is in use");
      end

   // Counter equals the free consumer slots, so never above the consumer depth
   credit_in_range: assert property (@(posedge clk) disable iff (reset_i)
      int'(credit_cnt_i) == int'(trace_pkg::EVENT_CREDITS) - outstanding)
      else begin
         fail_cnt++;
         $error("credit count differs from the free consumer slots");
      end

   // Quiet output while in reset
   no_send_in_reset: assert property (@(posedge clk) reset_i |-> !event_valid_i)
      else begin
         fail_cnt++;
         $error("event sent during reset");
      end

endmodule

bind trace_result trace_monitor_asserts u_asserts (
   .clk           (clk),
   .reset_i       (reset_i),
   .credit_cnt_i  (credit_q),
   .credit_i      (credit_i),
   .event_valid_i (event_valid_o)
);

/* test/trace_tests.txt */
# T valid pc insn wben wbreg wbdata | H hold | E kind value pc | F overflow terminated
# All fields hex, kind 1 exit 2 report 3 putc
T 1 00000100 9c600041 1 03 00000041
T 1 00000104 15000004 0 00 00000000
E 3 00000041 00000104
T 1 00000108 9c600000 1 03 12345678
T 1 0000010c 15000004 0 00 00000000
E 3 00000078 0000010c
T 1 00000110 9c800000 1 04 deadbeef
T 1 00000114 15000002 0 00 00000000
E 2 12345678 00000114
T 1 00000118 9c600000 1 03 cafef00d
T 1 0000011c 9ca00000 1 05 11111111
T 1 00000120 15000002 0 00 00000000
E 2 cafef00d 00000120
T 1 00000124 15000000 0 00 00000000
T 1 00000128 15000003 0 00 00000000
T 1 0000012c 15000104 0 00 00000000
T 1 00000130 e0632000 1 03 a5a5a5a5
H 1
T 1 00000200 15000002 0 00 00000000
T 1 00000204 15000002 0 00 00000000
T 1 00000208 15000002 0 00 00000000
T 1 0000020c 15000002 0 00 00000000
T 1 00000210 15000002 0 00 00000000
T 1 00000214 15000002 0 00 00000000
T 1 00000218 15000002 0 00 00000000
T 1 0000021c 15000002 0 00 00000000
T 1 00000220 15000002 0 00 00000000
T 1 00000224 15000002 0 00 00000000
T 0 00000000 00000000 0 00 00000000
T 0 00000000 00000000 0 00 00000000
E 2 a5a5a5a5 00000200
E 2 a5a5a5a5 00000204
E 2 a5a5a5a5 00000208
E 2 a5a5a5a5 0000020c
E 2 a5a5a5a5 00000210
E 2 a5a5a5a5 00000214
E 2 a5a5a5a5 00000218
E 2 a5a5a5a5 0000021c
H 0
T 1 00000300 9c600000 1 03 00000007
T 1 00000304 15000001 0 00 00000000
E 1 00000007 00000304
T 1 00000308 15000004 0 00 00000000
T 1 0000030c 15000002 0 00 00000000
F 1 1

/* vlog.f */
hw/trace_pkg.sv
hw/trace_decode.sv
hw/trace_execute.sv
hw/trace_result.sv
hw/trace_monitor.sv
test/trace_monitor_asserts.sv
test/tb_trace_monitor.sv
